/* src/hub75_params.svh */
// panel geometry, timing and command opcodes of the HUB75 driver
// included by the package, the RTL and the testbench
`ifndef HUB75_PARAMS_SVH
`define HUB75_PARAMS_SVH

// panel geometry
`define HUB75_WIDTH 16
`define HUB75_HEIGHT 8
`define HUB75_HALF 4            // rows per half-panel, one scan address each

// bitplanes for binary-coded modulation, equal to the bits per colour channel
`define HUB75_PLANES 4

// timing in clk_root cycles
`define HUB75_TICKS_PER_BIT 4   // uart bit time
`define HUB75_PIXEL_PERIOD 4    // one shifted pixel

// command opcodes, each followed by its argument bytes
`define HUB75_OP_LINE 8'h4C     // row byte, then one pixel of two bytes per column
`define HUB75_OP_RGB_EN 8'h45   // low 3 bits are the channel enables
`define HUB75_OP_PLANE_EN 8'h42 // low 4 bits are the bitplane enables

`endif

/* src/hub75_pkg.sv */
// types shared by the HUB75 driver modules and the testbench
// pull in with a wildcard import in the module header
`include "hub75_params.svh"

package hub75_pkg;

    // stored pixel, sent high byte first: {pad, r} then {g, b}
    typedef struct packed {
        logic [3:0]               pad;
        logic [`HUB75_PLANES-1:0] r;
        logic [`HUB75_PLANES-1:0] g;
        logic [`HUB75_PLANES-1:0] b;
    } pixel_t;

    // one bit per channel, as shifted into the panel
    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_t;

    typedef logic [$clog2(`HUB75_WIDTH)-1:0]  col_t;
    typedef logic [$clog2(`HUB75_HEIGHT)-1:0] row_t;
    typedef logic [$clog2(`HUB75_HALF)-1:0]   half_row_t;   // panel address lines
    typedef logic [$clog2(`HUB75_PLANES)-1:0] plane_t;
    typedef logic [`HUB75_PLANES-1:0]         plane_mask_t; // one bit per plane
    typedef logic [$clog2(`HUB75_WIDTH * `HUB75_HEIGHT)-1:0] ram_addr_t; // row * width + col

endpackage

/* src/uart_rx.sv */
// 8N1 uart receiver running at HUB75_TICKS_PER_BIT clocks per bit
// rx_strobe pulses for one cycle in the middle of a good stop bit
`timescale 1ns/1ps
`include "hub75_params.svh"

module uart_rx (
    input  logic       clk_root,
    input  logic       arst_n,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_strobe
);

    localparam int TICKS  = `HUB75_TICKS_PER_BIT;
    localparam int TICK_W = $clog2(TICKS);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t         state;
    logic [1:0]        rxd_sync;
    logic [TICK_W-1:0] tick;
    logic [2:0]        bit_idx;
    logic [7:0]        shift;
    logic              half_done;   // middle of the start bit
    logic              bit_done;    // middle of a data or stop bit

    assign half_done = (tick == TICK_W'(TICKS / 2 - 1));
    assign bit_done  = (tick == TICK_W'(TICKS - 1));

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            rxd_sync <= 2'b11; // line idles high
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
        end
    end

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state     <= RX_IDLE;
            tick      <= '0;
            bit_idx   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            tick      <= tick + 1'b1;
            case (state)
                RX_IDLE: begin
                    tick <= '0;
                    if (!rxd_sync[1]) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_done) begin
                        tick    <= '0;
                        bit_idx <= '0;
                        state   <= rxd_sync[1] ? RX_IDLE : RX_DATA; // glitch, not a start bit
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        tick    <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (bit_done) begin
                        rx_strobe <= rxd_sync[1]; // framing error drops the byte
                        state     <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_root) begin
        if (state == RX_DATA && bit_done) begin
            shift <= {rxd_sync[1], shift[7:1]}; // lsb first
        end
        if (state == RX_STOP && bit_done) begin
            rx_data <= shift;
        end
    end

endmodule

/* src/command_decoder.sv */
// command parser for the serial link
// turns line loads into frame memory writes and holds the channel and plane enables
`timescale 1ns/1ps
`include "hub75_params.svh"

module command_decoder
    import hub75_pkg::*;
(
    input  logic        clk_root,
    input  logic        arst_n,
    input  logic [7:0]  rx_data,
    input  logic        rx_strobe,
    output logic        wr_en,
    output ram_addr_t   wr_addr,
    output pixel_t      wr_data,
    output rgb_t        rgb_enable,
    output plane_mask_t plane_enable
);

    typedef enum logic [1:0] {
        ST_OPCODE,
        ST_ROW,     // argument byte, a row or an enable mask
        ST_PIX_HI,
        ST_PIX_LO
    } cmd_state_t;

    cmd_state_t state;
    logic [7:0] opcode;
    row_t       row;
    col_t       col;
    logic [7:0] pix_hi;
    logic       pix_done;

    assign pix_done = rx_strobe && (state == ST_PIX_LO);

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state        <= ST_OPCODE;
            opcode       <= '0;
            row          <= '0;
            col          <= '0;
            wr_en        <= 1'b0;
            rgb_enable   <= 3'b111;
            plane_enable <= '1;
        end else begin
            wr_en <= pix_done; // write lands one cycle after the low byte
            if (rx_strobe) begin
                case (state)
                    ST_OPCODE: begin
                        case (rx_data)
                            `HUB75_OP_LINE, `HUB75_OP_RGB_EN, `HUB75_OP_PLANE_EN: begin
                                opcode <= rx_data;
                                state  <= ST_ROW;
                            end
                            default: ; // unknown opcode, wait for the next one
                        endcase
                    end
                    ST_ROW: begin
                        state <= ST_OPCODE;
                        case (opcode)
                            `HUB75_OP_LINE: begin
                                row   <= row_t'(rx_data);
                                col   <= '0;
                                state <= ST_PIX_HI;
                            end
                            `HUB75_OP_RGB_EN:   rgb_enable   <= rgb_t'(rx_data[2:0]);
                            `HUB75_OP_PLANE_EN: plane_enable <= plane_mask_t'(rx_data[3:0]);
                            default: ;
                        endcase
                    end
                    ST_PIX_HI: state <= ST_PIX_LO;
                    ST_PIX_LO: begin
                        col <= col + 1'b1;
                        // last column closes the line
                        if (col == col_t'(`HUB75_WIDTH - 1)) begin
                            state <= ST_OPCODE;
                        end else begin
                            state <= ST_PIX_HI;
                        end
                    end
                    default: state <= ST_OPCODE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_root) begin
        if (rx_strobe && state == ST_PIX_HI) begin
            pix_hi <= rx_data;
        end
        if (pix_done) begin
            wr_addr <= ram_addr_t'(row * `HUB75_WIDTH + col);
            wr_data <= pixel_t'({pix_hi, rx_data});
        end
    end

endmodule

/* src/frame_ram.sv */
// frame buffer, one pixel_t word per panel pixel
// write port from the command decoder, registered read port for the row fetch
`timescale 1ns/1ps
`include "hub75_params.svh"

module frame_ram
    import hub75_pkg::*;
(
    input  logic      clk_root,
    input  logic      wr_en,
    input  ram_addr_t wr_addr,
    input  pixel_t    wr_data,
    input  ram_addr_t rd_addr,
    output pixel_t    rd_data
);

    localparam int DEPTH = `HUB75_WIDTH * `HUB75_HEIGHT;

    pixel_t mem [DEPTH];

    always_ff @(posedge clk_root) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // one cycle of read latency, old data on a same-address write
    always_ff @(posedge clk_root) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* src/row_fetch.sv */
// fetches the top and bottom pixel of one column after each load strobe
// and reduces them to the current bitplane bit per channel, masked by the enables
`timescale 1ns/1ps
`include "hub75_params.svh"

module row_fetch
    import hub75_pkg::*;
(
    input  logic        clk_root,
    input  logic        arst_n,
    input  logic        load,
    input  col_t        column,
    input  half_row_t   half_row,
    input  plane_t      plane,
    input  rgb_t        rgb_enable,
    input  plane_mask_t plane_enable,
    output ram_addr_t   rd_addr,
    input  pixel_t      rd_data,
    output rgb_t        rgb_top,
    output rgb_t        rgb_bottom
);

    logic [2:0] stage;      // one-hot, cycles 0 to 2 after load
    col_t       col_q;
    half_row_t  row_q;
    plane_t     plane_q;
    pixel_t     top_pix;

    function automatic rgb_t plane_bits(input pixel_t pix, input plane_t pl,
                                        input rgb_t en, input plane_mask_t pl_en);
        rgb_t bits;
        bits.r = pix.r[pl];
        bits.g = pix.g[pl];
        bits.b = pix.b[pl];
        return rgb_t'(bits & en & {3{pl_en[pl]}});
    endfunction

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            stage      <= '0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            stage <= {stage[1:0], load};
            if (stage[2]) begin // bottom word on rd_data now
                rgb_top    <= plane_bits(top_pix, plane_q, rgb_enable, plane_enable);
                rgb_bottom <= plane_bits(rd_data, plane_q, rgb_enable, plane_enable);
            end
        end
    end

    always_ff @(posedge clk_root) begin
        if (load) begin
            col_q   <= column;
            row_q   <= half_row;
            plane_q <= plane;
            rd_addr <= ram_addr_t'(half_row * `HUB75_WIDTH + column);
        end
        // bottom half sits HUB75_HALF rows further down
        if (stage[0]) begin
            rd_addr <= ram_addr_t'((row_q + `HUB75_HALF) * `HUB75_WIDTH + col_q);
        end
        if (stage[1]) begin
            top_pix <= rd_data;
        end
    end

endmodule

/* src/matrix_scan.sv */
// panel scan sequencer: shifts one column per pixel period, latches each bitplane
// and keeps the row lit for 8 << plane clocks while the next plane shifts
`timescale 1ns/1ps
`include "hub75_params.svh"

module matrix_scan
    import hub75_pkg::*;
(
    input  logic      clk_root,
    input  logic      arst_n,
    output logic      load,
    output col_t      column,
    output half_row_t half_row,
    output plane_t    plane,
    output half_row_t row_addr,
    output logic      clk_pixel,
    output logic      latch,
    output logic      oe_n
);

    localparam int PERIOD  = `HUB75_PIXEL_PERIOD;
    localparam int TICK_W  = $clog2(PERIOD);
    localparam int SLOTS   = `HUB75_WIDTH + 1;  // extra slot covers the fetch latency
    localparam int SLOT_W  = $clog2(SLOTS);
    localparam int ON_BASE = 8;                 // plane 0 on-time
    localparam int ON_W    = $clog2(ON_BASE << (`HUB75_PLANES - 1)) + 1;

    typedef enum logic [1:0] {
        PH_SHIFT,
        PH_BLANK,
        PH_LATCH
    } phase_t;

    phase_t            phase;
    logic [TICK_W-1:0] tick;
    logic [SLOT_W-1:0] slot;
    logic [ON_W-1:0]   on_cnt;
    logic              period_end;
    logic              shift_end;

    assign period_end = (phase == PH_SHIFT) && (tick == TICK_W'(PERIOD - 1));
    assign shift_end  = period_end && (slot == SLOT_W'(SLOTS - 1));
    // column k is fetched in slot k and clocked out in slot k+1
    assign load       = (phase == PH_SHIFT) && (tick == '0) && (slot < SLOT_W'(`HUB75_WIDTH));
    assign column     = col_t'(slot);

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            phase     <= PH_SHIFT;
            tick      <= '0;
            slot      <= '0;
            on_cnt    <= '0;
            plane     <= '0;
            half_row  <= '0;
            row_addr  <= '0;
            clk_pixel <= 1'b0;
            latch     <= 1'b0;
            oe_n      <= 1'b1;
        end else begin
            clk_pixel <= (phase == PH_SHIFT) && (tick == TICK_W'(PERIOD - 2)) && (slot != '0);
            latch     <= (phase == PH_BLANK);
            oe_n      <= (phase == PH_BLANK) || shift_end ||
                         ((phase == PH_SHIFT) && (on_cnt <= ON_W'(1)));
            case (phase)
                PH_SHIFT: begin
                    if (on_cnt != '0) begin
                        on_cnt <= on_cnt - 1'b1;
                    end
                    tick <= tick + 1'b1;
                    if (period_end) begin
                        tick <= '0;
                        slot <= shift_end ? '0 : slot + 1'b1;
                    end
                    if (shift_end) begin
                        phase <= PH_BLANK;
                    end
                end
                PH_BLANK: phase <= PH_LATCH;
                PH_LATCH: begin
                    phase    <= PH_SHIFT;
                    row_addr <= half_row;               // shows the row just latched
                    on_cnt   <= ON_W'(ON_BASE) << plane;
                    if (plane == plane_t'(`HUB75_PLANES - 1)) begin
                        plane    <= '0;
                        half_row <= (half_row == half_row_t'(`HUB75_HALF - 1)) ?
                                    '0 : half_row + 1'b1;
                    end else begin
                        plane <= plane + 1'b1;
                    end
                end
                default: phase <= PH_SHIFT;
            endcase
        end
    end

endmodule

/* src/hub75_top.sv */
// HUB75 driver top level, serial command input to panel pins
// uart receiver, command decoder, frame memory, row fetch and scan sequencer
`timescale 1ns/1ps

module hub75_top
    import hub75_pkg::*;
(
    input  logic      clk_root,
    input  logic      arst_n,
    input  logic      uart_rxd,
    output rgb_t      rgb1,     // top half-panel
    output rgb_t      rgb2,     // bottom half-panel
    output half_row_t row_addr,
    output logic      clk_pixel,
    output logic      latch,
    output logic      oe_n
);

    logic [7:0]  rx_data;
    logic        rx_strobe;
    logic        wr_en;
    ram_addr_t   wr_addr;
    pixel_t      wr_data;
    rgb_t        rgb_enable;
    plane_mask_t plane_enable;
    logic        load;
    col_t        column;
    half_row_t   half_row;
    plane_t      plane;
    ram_addr_t   rd_addr;
    pixel_t      rd_data;

    uart_rx u_uart_rx (
        .clk_root  (clk_root),
        .arst_n    (arst_n),
        .rxd       (uart_rxd),
        .rx_data   (rx_data),
        .rx_strobe (rx_strobe)
    );

    command_decoder u_command_decoder (
        .clk_root     (clk_root),
        .arst_n       (arst_n),
        .rx_data      (rx_data),
        .rx_strobe    (rx_strobe),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rgb_enable   (rgb_enable),
        .plane_enable (plane_enable)
    );

    frame_ram u_frame_ram (
        .clk_root (clk_root),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    row_fetch u_row_fetch (
        .clk_root     (clk_root),
        .arst_n       (arst_n),
        .load         (load),
        .column       (column),
        .half_row     (half_row),
        .plane        (plane),
        .rgb_enable   (rgb_enable),
        .plane_enable (plane_enable),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .rgb_top      (rgb1),
        .rgb_bottom   (rgb2)
    );

    matrix_scan u_matrix_scan (
        .clk_root  (clk_root),
        .arst_n    (arst_n),
        .load      (load),
        .column    (column),
        .half_row  (half_row),
        .plane     (plane),
        .row_addr  (row_addr),
        .clk_pixel (clk_pixel),
        .latch     (latch),
        .oe_n      (oe_n)
    );

endmodule

/* testbench/tb_clock.sv */
// clock and reset source for the HUB75 testbench
// 40 ns clk_root, arst_n held low for the first 5 cycles
`timescale 1ns/1ps

module tb_clock (
    output logic clk_root,
    output logic arst_n
);

    initial begin
        clk_root = 1'b0;
        forever #20 clk_root = ~clk_root;
    end

    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk_root);
        @(negedge clk_root);
        arst_n = 1'b1; // released away from the active edge
    end

endmodule

/* testbench/hub75_assertions.sv */
// panel timing assertions for hub75_top, attached by the bind at the end of this file
// each failure also sets a sticky flag that the testbench top reads
`timescale 1ns/1ps

module hub75_assertions (
    input logic clk_root,
    input logic arst_n,
    input logic latch,
    input logic oe_n,
    input logic clk_pixel
);

    logic latch_width_err;
    logic latch_blank_err;
    logic latch_clock_err;

    initial begin
        latch_width_err = 1'b0;
        latch_blank_err = 1'b0;
        latch_clock_err = 1'b0;
    end

    latch_single_cycle: assert property (
        @(posedge clk_root) disable iff (!arst_n) latch |=> !latch
    ) else begin
        latch_width_err = 1'b1;
        $error("latch held high for more than one cycle");
    end

    // panel must be dark while the shift register is copied
    latch_while_blank: assert property (
        @(posedge clk_root) disable iff (!arst_n) latch |-> oe_n
    ) else begin
        latch_blank_err = 1'b1;
        $error("latch high while oe_n is low");
    end

    latch_clock_quiet: assert property (
        @(posedge clk_root) disable iff (!arst_n) latch |-> !clk_pixel
    ) else begin
        latch_clock_err = 1'b1;
        $error("clk_pixel high during latch");
    end

endmodule

bind hub75_top hub75_assertions u_assertions (
    .clk_root  (clk_root),
    .arst_n    (arst_n),
    .latch     (latch),
    .oe_n      (oe_n),
    .clk_pixel (clk_pixel)
);

/* testbench/hub75_tb.sv */
// testbench for the HUB75 driver: loads random frames over the serial link and
// follows the scan, comparing every shifted line with a frame model
`timescale 1ns/1ps
`include "hub75_params.svh"

module hub75_tb
    import hub75_pkg::*;
();

    localparam int WIDTH      = `HUB75_WIDTH;
    localparam int HEIGHT     = `HUB75_HEIGHT;
    localparam int HALF       = `HUB75_HALF;
    localparam int PLANES     = `HUB75_PLANES;
    localparam int TICKS      = `HUB75_TICKS_PER_BIT;
    localparam int SCAN_LINES = HALF * PLANES;  // one full refresh
    localparam int LINE_CLKS  = (WIDTH + 1) * `HUB75_PIXEL_PERIOD + 2;
    localparam int RESET_MAX  = 20;
    localparam int ON_BASE    = 8;              // plane 0 on-time in clocks

    logic      clk_root;
    logic      arst_n;
    logic      uart_rxd;
    rgb_t      rgb1;
    rgb_t      rgb2;
    half_row_t row_addr;
    logic      clk_pixel;
    logic      latch;
    logic      oe_n;

    integer      seed;
    pixel_t      model_frame [WIDTH * HEIGHT];
    rgb_t        model_rgb_en;
    plane_mask_t model_plane_en;
    logic        cmd_busy;      // serial command in flight
    int          arm_count;     // bumped after each finished command

    rgb_t      line_top [WIDTH];
    rgb_t      line_bot [WIDTH];
    int        pix_idx;
    int        on_clks;         // oe_n low clocks since the last latch
    int        scan_line;       // shifts seen since reset
    int        arm_seen;
    int        lines_checked;
    logic      checking;
    logic      prev_clk_pixel;
    logic      row_pending;
    half_row_t row_expected;

    tb_clock u_clock (
        .clk_root (clk_root),
        .arst_n   (arst_n)
    );

    hub75_top dut (
        .clk_root  (clk_root),
        .arst_n    (arst_n),
        .uart_rxd  (uart_rxd),
        .rgb1      (rgb1),
        .rgb2      (rgb2),
        .row_addr  (row_addr),
        .clk_pixel (clk_pixel),
        .latch     (latch),
        .oe_n      (oe_n)
    );

    task automatic error_stop(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
        if (got !== exp) begin
            error_stop($sformatf("mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_row(input half_row_t got, input half_row_t exp, input string what);
        if (got !== exp) begin
            error_stop($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            error_stop($sformatf("mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    function automatic logic assertions_failed();
        return dut.u_assertions.latch_width_err || dut.u_assertions.latch_blank_err ||
               dut.u_assertions.latch_clock_err;
    endfunction

    // bit of one channel for this plane, dark when the plane or the channel is off
    function automatic rgb_t expected_bits(input int row, input int col, input plane_t pl);
        pixel_t pix;
        rgb_t   bits;
        pix  = model_frame[ram_addr_t'(row * WIDTH + col)];
        bits = '0;
        if (model_plane_en[pl]) begin
            bits.r = pix.r[pl] & model_rgb_en.r;
            bits.g = pix.g[pl] & model_rgb_en.g;
            bits.b = pix.b[pl] & model_rgb_en.b;
        end
        return bits;
    endfunction

    task automatic uart_bit(input logic value);
        uart_rxd = value;
        repeat (TICKS) @(negedge clk_root);
    endtask

    task automatic send_byte(input logic [7:0] data);
        logic [7:0] bits;
        int         i;
        bits = data;
        uart_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            uart_bit(bits[0]); // lsb first
            bits = bits >> 1;
        end
        uart_bit(1'b1);
    endtask

    task automatic begin_command();
        @(posedge clk_root);
        cmd_busy = 1'b1;
        @(negedge clk_root);
    endtask

    task automatic end_command();
        repeat (2 * TICKS) @(negedge clk_root); // strobe and ram write trail the stop bit
        @(posedge clk_root);
        cmd_busy = 1'b0;
        arm_count++;
    endtask

    task automatic load_row(input int row);
        logic [31:0] rnd;
        logic [15:0] word;
        int          col;
        begin_command();
        send_byte(`HUB75_OP_LINE);
        send_byte(8'(row));
        for (col = 0; col < WIDTH; col++) begin
            rnd  = $random(seed);
            word = rnd[15:0];
            model_frame[ram_addr_t'(row * WIDTH + col)] = pixel_t'(word);
            send_byte(word[15:8]);
            send_byte(word[7:0]);
        end
        end_command();
    endtask

    task automatic set_enables(input rgb_t chan, input plane_mask_t planes);
        begin_command();
        send_byte(`HUB75_OP_RGB_EN);
        send_byte({5'b0, chan});
        send_byte(`HUB75_OP_PLANE_EN);
        send_byte({4'b0, planes});
        model_rgb_en   = chan;
        model_plane_en = planes;
        end_command();
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk_root);
            check_level(oe_n, 1'b1, "oe_n in reset");
            check_level(latch, 1'b0, "latch in reset");
            check_level(clk_pixel, 1'b0, "clk_pixel in reset");
            cycles++;
            if (cycles > RESET_MAX) begin
                error_stop("reset was never released");
            end
        end while (arst_n !== 1'b1);
    endtask

    task automatic wait_checked_lines(input int count);
        int target;
        int cycles;
        target = lines_checked + count;
        cycles = 0;
        while (lines_checked < target) begin
            @(posedge clk_root);
            cycles++;
            if (cycles > (count + 2 * PLANES) * LINE_CLKS) begin
                error_stop("timed out waiting for checked scan lines");
            end
        end
    endtask

    // latch seen: compare the shifted line, then step the scan position
    task automatic close_line();
        int        col;
        int        exp_on;
        plane_t    pl;
        half_row_t hr;
        pl = plane_t'(scan_line % PLANES);
        hr = half_row_t'((scan_line / PLANES) % HALF);
        // panel lit during this shift for the plane latched one line earlier
        exp_on = (scan_line == 0) ? 0 : ON_BASE << ((scan_line - 1) % PLANES);
        if (on_clks != exp_on) begin
            error_stop($sformatf("mismatch at %0t: oe_n low for %0d clocks, expected %0d",
                                 $time, on_clks, exp_on));
        end
        if (checking) begin
            if (pix_idx != WIDTH) begin
                error_stop($sformatf("mismatch at %0t: %0d pixel clocks in a line, expected %0d",
                                     $time, pix_idx, WIDTH));
            end
            for (col = 0; col < WIDTH; col++) begin
                check_rgb(line_top[col_t'(col)], expected_bits(int'(hr), col, pl),
                          $sformatf("rgb1 row %0d plane %0d col %0d", hr, pl, col));
                check_rgb(line_bot[col_t'(col)], expected_bits(int'(hr) + HALF, col, pl),
                          $sformatf("rgb2 row %0d plane %0d col %0d", hr, pl, col));
            end
            lines_checked++;
        end
        row_expected = hr;
        row_pending  = 1'b1;
        pix_idx      = 0;
        on_clks      = 0;
        scan_line++;
        if (arm_seen != arm_count && !cmd_busy && scan_line % PLANES == 0) begin
            checking = 1'b1; // next shift is plane 0
            arm_seen = arm_count;
        end
    endtask

    always @(negedge clk_root) begin
        if (!arst_n) begin
            pix_idx        = 0;
            on_clks        = 0;
            scan_line      = 0;
            arm_seen       = 0;
            lines_checked  = 0;
            checking       = 1'b0;
            prev_clk_pixel = 1'b0;
            row_pending    = 1'b0;
        end else begin
            if (assertions_failed()) begin
                error_stop("a panel timing assertion failed");
            end
            if (cmd_busy) begin
                checking = 1'b0;
            end
            if (row_pending) begin
                check_row(row_addr, row_expected, "row_addr after latch");
                row_pending = 1'b0;
            end
            if (scan_line == 0) begin
                check_level(oe_n, 1'b1, "oe_n before the first latch");
            end
            if (clk_pixel && !prev_clk_pixel) begin
                if (pix_idx < WIDTH) begin
                    line_top[col_t'(pix_idx)] = rgb1;
                    line_bot[col_t'(pix_idx)] = rgb2;
                end
                pix_idx++;
            end
            prev_clk_pixel = clk_pixel;
            if (!oe_n) begin
                on_clks++;
            end
            if (latch) begin
                close_line();
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        rgb_t        chan_mask;
        plane_mask_t plane_mask;
        int          row;
        seed           = 32'he8d4;
        uart_rxd       = 1'b1; // idle line
        cmd_busy       = 1'b0;
        arm_count      = 0;
        model_rgb_en   = 3'b111;
        model_plane_en = 4'hF;
        wait_reset_release();

        for (row = 0; row < HEIGHT; row++) begin
            load_row(row);
        end
        wait_checked_lines(SCAN_LINES);

        // at least one channel switched off
        rnd       = $random(seed);
        chan_mask = rgb_t'(rnd[2:0]);
        if (chan_mask == 3'b111) begin
            chan_mask = 3'b010;
        end
        set_enables(chan_mask, 4'hF);
        wait_checked_lines(SCAN_LINES);

        // some planes on, some off
        rnd        = $random(seed);
        plane_mask = plane_mask_t'(rnd[3:0]);
        if (plane_mask == 4'hF || plane_mask == 4'h0) begin
            plane_mask = 4'b0110;
        end
        set_enables(3'b111, plane_mask);
        wait_checked_lines(SCAN_LINES);

        set_enables(3'b111, 4'hF);
        rnd = $random(seed);
        row = int'(rnd[2:0]);
        load_row(row);            // other rows keep their model data
        wait_checked_lines(SCAN_LINES);

        if (assertions_failed()) begin
            error_stop("a panel timing assertion failed");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

/* vlog.f */
+incdir+src
src/hub75_pkg.sv
src/uart_rx.sv
src/command_decoder.sv
src/frame_ram.sv
src/row_fetch.sv
src/matrix_scan.sv
src/hub75_top.sv
testbench/tb_clock.sv
testbench/hub75_assertions.sv
testbench/hub75_tb.sv

/* run.sh */
#!/bin/sh
# compiles the HUB75 testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module hub75_tb \
    --Mdir obj_dir -o hub75_sim

# the log check below decides the result, so a stopped run must not end the script here
./obj_dir/hub75_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "hub75 simulation passed"
else
    echo "hub75 simulation failed"
    exit 1
fi
